//--- frc_down_counter.sv
`timescale 1ns/1ps

module frc_down_counter
  import timer_count_pkg::*;
(
  input  logic           PCLK,
  input  logic           PRESETn,
  input  logic           timclken,
  timer_ctrl_if.datapath ctrl,
  input  logic           pre_tick,
  output count_t         count,
  output logic           carry_msb
);

  count_t     count_q;
  logic [1:0] carry_q;
  logic       stop_q;
  logic       stop1shot;
  logic       wrap;
  logic       reload;
  logic       step;
  half_t      nxt_low;
  half_t      nxt_high;
  half_t      high_src;
  logic       nxt_carry_0;
  logic       nxt_carry_1;
  count_t     count_mux;

  // --------------------------------------------------------------------------
  // One-shot stop
  // --------------------------------------------------------------------------

  // Periodic reload when zero was reached
  assign wrap   = carry_msb & ctrl.timer_mode;
  // Either source of a new start value
  assign reload = ctrl.load_req | wrap;

  // Set at zero in one-shot mode, released by a load or by leaving one-shot
  always_comb
  begin
    if (ctrl.load_req || !ctrl.one_shot)
      stop1shot = 1'b0;
    else if (carry_msb)
      stop1shot = 1'b1;
    else
      stop1shot = stop_q;
  end

  // Count step qualifier
  assign step = ctrl.timer_en & pre_tick & ~stop1shot;

  // --------------------------------------------------------------------------
  // Split decrement and carry look-ahead
  // --------------------------------------------------------------------------

  // Low half steps every time
  assign nxt_low = count_q[HALF_W-1:0] - 1'b1;

  // High half steps only in 32-bit mode on a low borrow
  assign nxt_high = (ctrl.timer_size && carry_q[0]) ?
                    count_q[COUNT_W-1:HALF_W] - 1'b1 :
                    count_q[COUNT_W-1:HALF_W];

  // Low carry predicted from the reload value on a load or wrap
  always_comb
  begin
    if (reload)
      nxt_carry_0 = (ctrl.load_period[HALF_W-1:0] == '0);
    else
      nxt_carry_0 = (count_q[HALF_W-1:0] == half_t'(1));
  end

  assign high_src = reload ? ctrl.load_period[COUNT_W-1:HALF_W] :
                             count_q[COUNT_W-1:HALF_W];

  // In 16-bit mode the high carry tracks the low one
  always_comb
  begin
    if (!ctrl.timer_size)
      nxt_carry_1 = nxt_carry_0;
    else
      nxt_carry_1 = nxt_carry_0 & ~carry_msb & (high_src == '0);
  end

  // --------------------------------------------------------------------------
  // Count register
  // --------------------------------------------------------------------------

  // Load first, then periodic reload, then plain decrement
  always_comb
  begin
    if (ctrl.load_req)
      count_mux = ctrl.load_val;
    else if (wrap)
      count_mux = ctrl.load_period;
    else
      count_mux = {nxt_high, nxt_low};
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      count_q <= COUNT_RESET;
      carry_q <= 2'b00;
      stop_q  <= 1'b0;
    end
    else if (timclken)
    begin
      stop_q <= stop1shot;
      // Carries move with the count
      if (step || ctrl.load_req)
      begin
        count_q <= count_mux;
        carry_q <= {nxt_carry_1, nxt_carry_0};
      end
    end
  end

  // Zero reached, for the selected counter size
  assign carry_msb = ctrl.timer_size ? carry_q[1] : carry_q[0];
  assign count     = count_q;

endmodule

//--- frc_irq.sv
`timescale 1ns/1ps

module frc_irq (
  input  logic PCLK,
  input  logic PRESETn,
  input  logic timclken,
  input  logic carry_msb,
  input  logic int_clr_req,
  input  logic int_enable,
  output logic raw_int,
  output logic masked_int
);

  logic clr_active;
  logic clr_hold_q;
  logic nxt_raw;
  logic raw_q;

  // --------------------------------------------------------------------------
  // Clear hold
  // --------------------------------------------------------------------------

  // carry_msb may stay high for many cycles after zero
  // so the clear is kept until it falls, else the flag would set again
  always_comb
  begin
    if (int_clr_req)
      clr_active = 1'b1;
    else if (!carry_msb)
      clr_active = 1'b0;
    else
      clr_active = clr_hold_q;
  end

  // --------------------------------------------------------------------------
  // Raw interrupt latch
  // --------------------------------------------------------------------------

  // Sets on zero, held until cleared
  assign nxt_raw = (carry_msb | raw_q) & ~clr_active;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      clr_hold_q <= 1'b0;
      raw_q      <= 1'b0;
    end
    else if (timclken)
    begin
      clr_hold_q <= clr_active;
      raw_q      <= nxt_raw;
    end
  end

  // Status reads show the clear in the same cycle
  assign raw_int    = raw_q & ~clr_active;
  assign masked_int = raw_int & int_enable;

endmodule

//--- frc_prescaler.sv
`timescale 1ns/1ps

module frc_prescaler
  import timer_count_pkg::*;
(
  input  logic           PCLK,
  input  logic           PRESETn,
  input  logic           timclken,
  timer_ctrl_if.datapath ctrl,
  output logic           pre_tick
);

  prescale_t pre_cnt;
  logic      tick_16;
  logic      tick_256;

  // --------------------------------------------------------------------------
  // Prescale down-counter
  // --------------------------------------------------------------------------

  // Cleared on a load so the first period is full length
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
      pre_cnt <= '0;
    else if (timclken)
    begin
      if (ctrl.load_req)
        pre_cnt <= '0;
      else if (ctrl.timer_en)
        pre_cnt <= pre_cnt - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Tick selection
  // --------------------------------------------------------------------------

  // Once every 16 enabled edges
  assign tick_16  = (pre_cnt[3:0] == 4'h1);
  // Once every 256 enabled edges
  assign tick_256 = (pre_cnt == prescale_t'(1));

  always_comb
  begin
    case (ctrl.timer_pre)
      PRE_DIV1:   pre_tick = 1'b1;
      PRE_DIV16:  pre_tick = tick_16;
      PRE_DIV256: pre_tick = tick_256;
      // Undefined code runs as divide by 256
      default:    pre_tick = tick_256;
    endcase
  end

endmodule

//--- frc_reg_block.sv
`timescale 1ns/1ps

module frc_reg_block
  import timer_regs_pkg::*;
  import timer_count_pkg::*;
(
  input  logic       PCLK,
  input  logic       PRESETn,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  reg_addr_t  paddr,
  input  bus_data_t  pwdata,
  input  count_t     count,
  input  logic       raw_int,
  input  logic       masked_int,
  timer_ctrl_if.regs ctrl,
  output logic       int_clr_req,
  output bus_data_t  prdata
);

  logic      wr_setup;
  logic      ctrl_wr;
  logic      load_wr;
  logic      loadbg_wr;
  logic      clr_wr;
  ctrl_reg_t ctrl_wdata;
  ctrl_reg_t ctrl_q;
  logic      load_req_q;
  count_t    load_val_q;
  count_t    load_period_q;
  count_t    count_read;

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------

  // Writes act in the setup phase only
  assign wr_setup  = psel & pwrite & ~penable;
  assign ctrl_wr   = wr_setup & (paddr == ADDR_CONTROL);
  assign load_wr   = wr_setup & (paddr == ADDR_LOAD);
  assign loadbg_wr = wr_setup & (paddr == ADDR_LOADBG);
  assign clr_wr    = wr_setup & (paddr == ADDR_CLEAR);

  // Reserved bit dropped before storing
  always_comb
  begin
    ctrl_wdata            = pwdata[$bits(ctrl_reg_t)-1:0];
    ctrl_wdata[CTRL_RSVD] = 1'b0;
  end

  // --------------------------------------------------------------------------
  // Control, load and period registers
  // --------------------------------------------------------------------------
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ctrl_q        <= CTRL_RESET;
      load_period_q <= '0;
      load_req_q    <= 1'b0;
      int_clr_req   <= 1'b0;
    end
    else
    begin
      if (ctrl_wr)
        ctrl_q <= ctrl_wdata;
      // Period follows both a load and a background load
      if (load_wr || loadbg_wr)
        load_period_q <= pwdata;
      // Request pulses, high for the cycle after the write
      load_req_q  <= load_wr;
      int_clr_req <= clr_wr;
    end
  end

  // Direct load value, only consumed while load_req is high
  always_ff @(posedge PCLK)
  begin
    if (load_wr)
      load_val_q <= pwdata;
  end

  // Control fields out to the datapath
  assign ctrl.timer_en    = ctrl_q[CTRL_EN];
  assign ctrl.timer_mode  = ctrl_q[CTRL_MODE];
  assign ctrl.int_enable  = ctrl_q[CTRL_INTEN];
  assign ctrl.timer_pre   = ctrl_q[CTRL_PRE_LSB +: PRE_SEL_W];
  assign ctrl.timer_size  = ctrl_q[CTRL_SIZE];
  assign ctrl.one_shot    = ctrl_q[CTRL_ONESHOT];
  assign ctrl.load_req    = load_req_q;
  assign ctrl.load_val    = load_val_q;
  assign ctrl.load_period = load_period_q;

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------

  // Show the new load value before the counter has taken it
  assign count_read = load_req_q ? load_val_q : count;

  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      case (paddr)
        ADDR_LOAD:    prdata = load_period_q;
        ADDR_VALUE:   prdata = count_read;
        ADDR_CONTROL: prdata[$bits(ctrl_reg_t)-1:0] = ctrl_q;
        // Status bits sit in bit 0
        ADDR_INTRAW:  prdata[0] = raw_int;
        ADDR_INT:     prdata[0] = masked_int;
        ADDR_LOADBG:  prdata = load_period_q;
        default:      prdata = '0;
      endcase
    end
  end

endmodule

//--- frc_timer.sv
`timescale 1ns/1ps

module frc_timer
  import timer_regs_pkg::*;
  import timer_count_pkg::*;
(
  input  logic      PCLK,
  input  logic      PRESETn,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  reg_addr_t paddr,
  input  bus_data_t pwdata,
  input  logic      timclken,
  output bus_data_t prdata,
  output logic      frc_int
);

  // Datapath to register block
  count_t count;
  logic   raw_int;
  // Register block to datapath
  logic   int_clr_req;
  logic   pre_tick;
  logic   carry_msb;

  // Control fields and load requests
  timer_ctrl_if ctrl_bus ();

  // --------------------------------------------------------------------------
  // Register block
  // --------------------------------------------------------------------------
  frc_reg_block u_regs (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .count       (count),
    .raw_int     (raw_int),
    .masked_int  (frc_int),
    .ctrl        (ctrl_bus.regs),
    .int_clr_req (int_clr_req),
    .prdata      (prdata)
  );

  // --------------------------------------------------------------------------
  // Timer datapath
  // --------------------------------------------------------------------------
  frc_prescaler u_prescaler (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .timclken (timclken),
    .ctrl     (ctrl_bus.datapath),
    .pre_tick (pre_tick)
  );

  frc_down_counter u_counter (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .timclken  (timclken),
    .ctrl      (ctrl_bus.datapath),
    .pre_tick  (pre_tick),
    .count     (count),
    .carry_msb (carry_msb)
  );

  // Masked status doubles as the interrupt pin
  frc_irq u_irq (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .timclken    (timclken),
    .carry_msb   (carry_msb),
    .int_clr_req (int_clr_req),
    .int_enable  (ctrl_bus.int_enable),
    .raw_int     (raw_int),
    .masked_int  (frc_int)
  );

endmodule

//--- sources.f
timer_regs_pkg.sv
timer_count_pkg.sv
timer_ctrl_if.sv
frc_reg_block.sv
frc_prescaler.sv
frc_down_counter.sv
frc_irq.sv
frc_timer.sv
tb_frc_timer.sv

//--- tb_frc_timer.sv
`timescale 1ns/1ps

module tb_frc_timer
  import timer_regs_pkg::*;
  import timer_count_pkg::*;
();

  // How the VALUE read of a table entry is judged
  localparam int VAL_EXACT   = 0;
  localparam int VAL_MAX     = 1;
  localparam int VAL_NONZERO = 2;

  localparam int MAX_ENTRIES     = 16;
  // Reset, reset-value reads and the register read-back loop
  localparam int PROLOGUE_CYCLES = 50;
  // Bus accesses of one entry at two cycles each
  localparam int ENTRY_CYCLES    = 20;

  logic      PCLK;
  logic      PRESETn;
  logic      psel;
  logic      penable;
  logic      pwrite;
  reg_addr_t paddr;
  bus_data_t pwdata;
  logic      timclken;
  bus_data_t prdata;
  logic      frc_int;

  // Stimulus and expected-value table
  string     t_name   [0:MAX_ENTRIES-1];
  logic      t_setup  [0:MAX_ENTRIES-1];
  ctrl_reg_t t_ctrl   [0:MAX_ENTRIES-1];
  count_t    t_load   [0:MAX_ENTRIES-1];
  logic      t_use_bg [0:MAX_ENTRIES-1];
  count_t    t_loadbg [0:MAX_ENTRIES-1];
  logic      t_clear  [0:MAX_ENTRIES-1];
  int        t_wait   [0:MAX_ENTRIES-1];
  int        t_vmode  [0:MAX_ENTRIES-1];
  bus_data_t t_value  [0:MAX_ENTRIES-1];
  logic      t_raw    [0:MAX_ENTRIES-1];
  logic      t_int    [0:MAX_ENTRIES-1];
  logic      t_frc    [0:MAX_ENTRIES-1];

  int        n_entries;
  int        n_pass;
  int        n_fail;
  int        timeout_limit;
  int        cycle_cnt;
  logic      table_ready;
  logic [31:0] rng;

  frc_timer dut (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .timclken (timclken),
    .prdata   (prdata),
    .frc_int  (frc_int)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #5 PCLK = ~PCLK;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Setup phase then access phase
  // The write lands on the second edge
  task automatic bus_write(input reg_addr_t addr, input bus_data_t data);
    @(posedge PCLK);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    penable <= 1'b0;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge PCLK);
    penable <= 1'b1;
  endtask

  // prdata is combinational and taken mid-cycle in the access phase
  task automatic bus_read(input reg_addr_t addr, output bus_data_t data);
    @(posedge PCLK);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    penable <= 1'b0;
    paddr   <= addr;
    @(posedge PCLK);
    penable <= 1'b1;
    @(negedge PCLK);
    data = prdata;
  endtask

  task automatic check_word(input string name, input bus_data_t exp, input bus_data_t act);
    if (act === exp)
    begin
      n_pass++;
      $display("ok    %s = %h", name, act);
    end
    else
    begin
      n_fail++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act === exp)
    begin
      n_pass++;
      $display("ok    %s = %b", name, act);
    end
    else
    begin
      n_fail++;
      $display("Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_max(input string name, input bus_data_t limit, input bus_data_t act);
    if ((act <= limit) === 1'b1)
    begin
      n_pass++;
      $display("ok    %s = %h", name, act);
    end
    else
    begin
      n_fail++;
      $display("Error: %s expected <= %h actual %h", name, limit, act);
    end
  endtask

  task automatic add_entry(input string name, input logic setup, input ctrl_reg_t ctrl,
                           input count_t load, input logic use_bg, input count_t loadbg,
                           input logic clear, input int wait_cyc, input int vmode,
                           input bus_data_t value, input logic raw, input logic int_m,
                           input logic frc);
    t_name[n_entries]   = name;
    t_setup[n_entries]  = setup;
    t_ctrl[n_entries]   = ctrl;
    t_load[n_entries]   = load;
    t_use_bg[n_entries] = use_bg;
    t_loadbg[n_entries] = loadbg;
    t_clear[n_entries]  = clear;
    t_wait[n_entries]   = wait_cyc;
    t_vmode[n_entries]  = vmode;
    t_value[n_entries]  = value;
    t_raw[n_entries]    = raw;
    t_int[n_entries]    = int_m;
    t_frc[n_entries]    = frc;
    n_entries++;
  endtask

  // --------------------------------------------------------------------------
  // Table
  // --------------------------------------------------------------------------
  task automatic build_table();
    int sum_wait;
    n_entries = 0;
    // With the timer off the load shows at once and holds
    add_entry("disabled_load", 1, 8'h20, 32'h1234_5678, 0, 0, 0, 0, VAL_EXACT,
              32'h1234_5678, 0, 0, 0);
    add_entry("disabled_hold", 0, 8'h20, 0, 0, 0, 0, 10, VAL_EXACT,
              32'h1234_5678, 0, 0, 0);
    // 32-bit one-shot at divide by 1 with and without interrupt enable
    add_entry("oneshot32_irq", 1, 8'hA3, 32'd5, 0, 0, 0, 20, VAL_EXACT, 32'd0, 1, 1, 1);
    add_entry("oneshot32_masked", 1, 8'h83, 32'd5, 0, 0, 0, 20, VAL_EXACT, 32'd0, 1, 0, 0);
    // 16-bit one-shot leaves the high half alone
    add_entry("oneshot16_stop", 1, 8'hA1, 32'h0002_0003, 0, 0, 0, 20, VAL_EXACT,
              32'h0002_0000, 1, 1, 1);
    // Clear is held while the counter sits at zero
    add_entry("oneshot16_clear", 0, 8'hA1, 0, 0, 0, 1, 10, VAL_EXACT,
              32'h0002_0000, 0, 0, 0);
    // Periodic reload from the background value
    add_entry("periodic_reload", 1, 8'hE2, 32'd3, 1, 32'd7, 0, 40, VAL_MAX, 32'd7, 1, 1, 1);
    // Divide by 16 gives one step per 16 cycles
    add_entry("div16_early", 1, 8'hA7, 32'd2, 0, 0, 0, 16, VAL_NONZERO, 32'd0, 0, 0, 0);
    add_entry("div16_done", 0, 8'hA7, 0, 0, 0, 0, 44, VAL_EXACT, 32'd0, 1, 1, 1);

    sum_wait = 0;
    for (int i = 0; i < n_entries; i++)
      sum_wait += t_wait[i];
    timeout_limit = PROLOGUE_CYCLES + sum_wait + ENTRY_CYCLES * n_entries;
    table_ready   = 1'b1;
  endtask

  task automatic run_entry(input int i);
    ctrl_reg_t ctrl_off;
    bus_data_t v;
    bus_data_t max_seen;
    int        elapsed;
    if (t_setup[i])
    begin
      // Stop the timer, load, drop old status, then start
      ctrl_off          = t_ctrl[i];
      ctrl_off[CTRL_EN] = 1'b0;
      bus_write(ADDR_CONTROL, bus_data_t'(ctrl_off));
      bus_write(ADDR_LOAD, t_load[i]);
      if (t_use_bg[i])
        bus_write(ADDR_LOADBG, t_loadbg[i]);
      bus_write(ADDR_CLEAR, '0);
      bus_write(ADDR_CONTROL, bus_data_t'(t_ctrl[i]));
    end
    if (t_clear[i])
      bus_write(ADDR_CLEAR, '0);

    elapsed  = 0;
    max_seen = '0;
    if (t_vmode[i] == VAL_MAX)
    begin
      // Poll VALUE through the wait
      while (elapsed < t_wait[i])
      begin
        bus_read(ADDR_VALUE, v);
        if (v > max_seen || $isunknown(v))
          max_seen = v;
        elapsed += 2;
      end
    end
    else
      repeat (t_wait[i]) @(posedge PCLK);

    bus_read(ADDR_VALUE, v);
    case (t_vmode[i])
      VAL_MAX:
      begin
        if (v > max_seen || $isunknown(v))
          max_seen = v;
        check_max({t_name[i], " VALUE"}, t_value[i], max_seen);
      end
      VAL_NONZERO: check_bit({t_name[i], " VALUE nonzero"}, 1'b1, v != '0);
      default:     check_word({t_name[i], " VALUE"}, t_value[i], v);
    endcase
    bus_read(ADDR_INTRAW, v);
    check_word({t_name[i], " INTRAW"}, bus_data_t'(t_raw[i]), v);
    bus_read(ADDR_INT, v);
    check_word({t_name[i], " INT"}, bus_data_t'(t_int[i]), v);
    @(negedge PCLK);
    check_bit({t_name[i], " frc_int"}, t_frc[i], frc_int);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    bus_data_t v;
    bus_data_t wdata;
    reg_addr_t waddr;
    psel        <= 1'b0;
    penable     <= 1'b0;
    pwrite      <= 1'b0;
    paddr       <= '0;
    pwdata      <= '0;
    timclken    <= 1'b1;
    PRESETn     <= 1'b0;
    n_pass      = 0;
    n_fail      = 0;
    table_ready = 1'b0;
    rng         = 32'hfcb1;
    build_table();
    repeat (4) @(posedge PCLK);
    PRESETn <= 1'b1;

    // Reset values
    bus_read(ADDR_CONTROL, v);
    check_word("reset CONTROL", 32'h0000_0020, v);
    bus_read(ADDR_VALUE, v);
    check_word("reset VALUE", 32'hFFFF_FFFF, v);
    bus_read(ADDR_INTRAW, v);
    check_word("reset INTRAW", '0, v);

    // Reserved bit 4 never reads back
    wdata = 32'h0000_0034;
    bus_write(ADDR_CONTROL, wdata);
    bus_read(ADDR_CONTROL, v);
    check_word("CONTROL rsvd bit", 32'h0000_0024, v);

    // Both load addresses share one period register
    for (int i = 0; i < 4; i++)
    begin
      rng   = xorshift32(rng);
      waddr = (i % 2 == 1) ? ADDR_LOADBG : ADDR_LOAD;
      bus_write(waddr, rng);
      bus_read(ADDR_LOAD, v);
      check_word($sformatf("period %0d via LOAD", i), rng, v);
      bus_read(ADDR_LOADBG, v);
      check_word($sformatf("period %0d via LOADBG", i), rng, v);
    end

    for (int i = 0; i < n_entries; i++)
      run_entry(i);

    $display("Checks: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Watchdog on the total cycle budget
  initial
  begin
    cycle_cnt = 0;
    wait (table_ready === 1'b1);
    while (cycle_cnt < timeout_limit)
    begin
      @(posedge PCLK);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- timer_count_pkg.sv
package timer_count_pkg;

  // --------------------------------------------------------------------------
  // Counter and prescaler widths
  // --------------------------------------------------------------------------
  localparam int COUNT_W    = 32;
  // Counter is split in two half-words for the 16/32-bit carry
  localparam int HALF_W     = COUNT_W / 2;
  localparam int PRESCALE_W = 8;
  localparam int PRE_SEL_W  = 2;

  typedef logic [COUNT_W-1:0]    count_t;
  typedef logic [HALF_W-1:0]     half_t;
  typedef logic [PRESCALE_W-1:0] prescale_t;
  typedef logic [PRE_SEL_W-1:0]  pre_sel_t;

  // --------------------------------------------------------------------------
  // Prescale select codes
  // --------------------------------------------------------------------------
  localparam pre_sel_t PRE_DIV1   = 2'b00;
  localparam pre_sel_t PRE_DIV16  = 2'b01;
  // Code 2'b11 behaves as divide by 256 too
  localparam pre_sel_t PRE_DIV256 = 2'b10;

  // Counter starts at all ones so no early interrupt
  localparam count_t COUNT_RESET = '1;

endpackage

//--- timer_ctrl_if.sv
`timescale 1ns/1ps

interface timer_ctrl_if
  import timer_count_pkg::*;
  ();

  // Control register fields
  logic     timer_en;
  logic     timer_mode;
  logic     int_enable;
  pre_sel_t timer_pre;
  logic     timer_size;
  logic     one_shot;

  // One-cycle pulse, count takes load_val on the next enabled edge
  logic     load_req;
  // Value for a direct load
  count_t   load_val;
  // Reload value used on a periodic wrap
  count_t   load_period;

  // Register block side
  modport regs (
    output timer_en, timer_mode, int_enable, timer_pre,
    output timer_size, one_shot,
    output load_req, load_val, load_period
  );

  // Prescaler, counter and interrupt side
  modport datapath (
    input timer_en, timer_mode, int_enable, timer_pre,
    input timer_size, one_shot,
    input load_req, load_val, load_period
  );

endinterface

//--- timer_regs_pkg.sv
package timer_regs_pkg;

  // --------------------------------------------------------------------------
  // Bus and register widths
  // --------------------------------------------------------------------------

  // Word address, taken from paddr[4:2]
  localparam int ADDR_W = 3;
  // Peripheral bus data word
  localparam int DATA_W = 32;
  // Control register image
  localparam int CTRL_W = 8;

  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0] bus_data_t;
  typedef logic [CTRL_W-1:0] ctrl_reg_t;

  // --------------------------------------------------------------------------
  // Register map, word offsets
  // --------------------------------------------------------------------------
  localparam reg_addr_t ADDR_LOAD    = 3'd0;
  localparam reg_addr_t ADDR_VALUE   = 3'd1;
  localparam reg_addr_t ADDR_CONTROL = 3'd2;
  // Write only, any data clears the interrupt
  localparam reg_addr_t ADDR_CLEAR   = 3'd3;
  localparam reg_addr_t ADDR_INTRAW  = 3'd4;
  localparam reg_addr_t ADDR_INT     = 3'd5;
  localparam reg_addr_t ADDR_LOADBG  = 3'd6;

  // --------------------------------------------------------------------------
  // Control register fields
  // --------------------------------------------------------------------------
  localparam int CTRL_EN      = 7;
  localparam int CTRL_MODE    = 6;
  localparam int CTRL_INTEN   = 5;
  // Reserved bit, always reads as zero
  localparam int CTRL_RSVD    = 4;
  // Prescale select occupies bits 3:2
  localparam int CTRL_PRE_LSB = 2;
  localparam int CTRL_SIZE    = 1;
  localparam int CTRL_ONESHOT = 0;

  // Timer off, free running, 16-bit, interrupt enabled
  localparam ctrl_reg_t CTRL_RESET = 8'h20;

endpackage
